// File: hdl/mem_port_arbiter.sv
`timescale 1ns/100ps

module mem_port_arbiter (
   input  versat_pkg::mem_req_t host_req,
   input  versat_pkg::mem_req_t rd_req,
   input  versat_pkg::mem_req_t wr_req,
   output versat_pkg::mem_req_t mem_req,
   output logic                 rd_grant,
   output logic                 wr_grant
);
   import versat_pkg::*;

   logic host_win;
   logic wr_win;
   logic rd_win;

   // host first, then write-back, then read
   assign host_win = host_req.valid;
   assign wr_win   = wr_req.valid & ~host_win;
   assign rd_win   = rd_req.valid & ~host_win & ~wr_req.valid;

   always_comb begin
      if (host_win)
         mem_req = host_req;
      else if (wr_win)
         mem_req = wr_req;
      else if (rd_win)
         mem_req = rd_req;
      else
         mem_req = '0;
   end

   assign rd_grant = rd_win;
   assign wr_grant = wr_win;

endmodule

// File: hdl/stage_alu.sv
`timescale 1ns/100ps

module stage_alu (
   input  versat_pkg::alu_op_e op,
   input  versat_pkg::data_t   a,
   input  versat_pkg::data_t   b,
   output versat_pkg::data_t   result
);
   import versat_pkg::*;

   always_comb begin
      case (op)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         // unsigned compare
         ALU_MAX:  result = (a > b) ? a : b;
         ALU_PASS: result = a;
         // unused code acts as pass
         default:  result = a;
      endcase
   end

endmodule

// File: hdl/stage_config.sv
`timescale 1ns/100ps

module stage_config (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   cfg_valid,
   input  logic                   cfg_we,
   input  versat_pkg::cfg_idx_t   cfg_idx,
   input  versat_pkg::data_t      cfg_wdata,
   output versat_pkg::data_t      cfg_rdata,
   output versat_pkg::stage_cfg_t cfg
);
   import versat_pkg::*;

   stage_cfg_t cfg_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cfg_q <= '0;
      end else if (cfg_valid && cfg_we) begin
         case (cfg_idx)
            CFG_OP:    cfg_q.op        <= alu_op_e'(cfg_wdata[2:0]);
            CFG_SRC:   cfg_q.src       <= cfg_wdata[ADDR_W-1:0];
            CFG_DST:   cfg_q.dst       <= cfg_wdata[ADDR_W-1:0];
            CFG_ITER:  cfg_q.iter      <= cfg_wdata[ADDR_W-1:0];
            CFG_CONST: cfg_q.const_val <= cfg_wdata;
            CFG_BSEL:  cfg_q.bsel      <= cfg_wdata[0];
            default: ;
         endcase
      end
   end

   // read-back zero-extended to the bus width
   always_comb begin
      case (cfg_idx)
         CFG_OP:    cfg_rdata = data_t'(cfg_q.op);
         CFG_SRC:   cfg_rdata = data_t'(cfg_q.src);
         CFG_DST:   cfg_rdata = data_t'(cfg_q.dst);
         CFG_ITER:  cfg_rdata = data_t'(cfg_q.iter);
         CFG_CONST: cfg_rdata = cfg_q.const_val;
         CFG_BSEL:  cfg_rdata = data_t'(cfg_q.bsel);
         default:   cfg_rdata = '0;
      endcase
   end

   assign cfg = cfg_q;

endmodule

// File: hdl/stage_mem.sv
`timescale 1ns/100ps

module stage_mem #(
   parameter int MEM_AW = 5
) (
   input  logic                 clk,
   input  versat_pkg::mem_req_t mem_req,
   output versat_pkg::data_t    rdata
);
   import versat_pkg::*;

   data_t mem [2**MEM_AW];

   // read data holds until the next read
   always_ff @(posedge clk) begin
      if (mem_req.valid) begin
         if (mem_req.we)
            mem[mem_req.addr[MEM_AW-1:0]] <= mem_req.wdata;
         else
            rdata <= mem[mem_req.addr[MEM_AW-1:0]];
      end
   end

endmodule

// File: hdl/stream_engine.sv
`timescale 1ns/100ps

module stream_engine (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   run,
   input  versat_pkg::stage_cfg_t cfg,
   input  versat_pkg::data_t      flow_in,
   input  logic                   rd_grant,
   input  logic                   wr_grant,
   input  versat_pkg::data_t      alu_result,
   output logic                   busy,
   output versat_pkg::mem_req_t   rd_req,
   output versat_pkg::mem_req_t   wr_req,
   output versat_pkg::data_t      operand_b,
   output versat_pkg::alu_op_e    op,
   output versat_pkg::data_t      flow_out
);
   import versat_pkg::*;

   engine_state_e state;
   addr_t         cnt;
   addr_t         src_q;
   addr_t         dst_q;
   alu_op_e       op_q;
   data_t         b_q;
   data_t         wdata_q;
   data_t         result_q;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state    <= ENG_IDLE;
         cnt      <= '0;
         result_q <= '0;
      end else begin
         case (state)
            ENG_IDLE: begin
               // run only starts an idle engine
               if (run) begin
                  state <= ENG_READ;
                  cnt   <= cfg.iter;
               end
            end
            ENG_READ: begin
               if (cnt == '0)
                  state <= ENG_IDLE;
               else if (rd_grant)
                  state <= ENG_WAIT;
            end
            ENG_WAIT: state <= ENG_WRITE;
            ENG_WRITE: begin
               if (wr_grant) begin
                  result_q <= wdata_q;
                  cnt      <= cnt - 1'b1;
                  state    <= (cnt == addr_t'(1)) ? ENG_IDLE : ENG_READ;
               end
            end
            default: state <= ENG_IDLE;
         endcase
      end
   end

   // run setup and item data
   always_ff @(posedge clk) begin
      if (state == ENG_IDLE && run) begin
         src_q <= cfg.src;
         dst_q <= cfg.dst;
         op_q  <= cfg.op;
         b_q   <= cfg.bsel ? flow_in : cfg.const_val;
      end
      if (state == ENG_READ && rd_grant)
         src_q <= src_q + 1'b1;
      // capture now, the host may take the port before the write-back
      if (state == ENG_WAIT)
         wdata_q <= alu_result;
      if (state == ENG_WRITE && wr_grant)
         dst_q <= dst_q + 1'b1;
   end

   assign rd_req.valid = (state == ENG_READ) && (cnt != '0);
   assign rd_req.we    = 1'b0;
   assign rd_req.addr  = src_q;
   assign rd_req.wdata = '0;

   assign wr_req.valid = (state == ENG_WRITE);
   assign wr_req.we    = 1'b1;
   assign wr_req.addr  = dst_q;
   assign wr_req.wdata = wdata_q;

   assign busy      = (state != ENG_IDLE);
   assign operand_b = b_q;
   assign op        = op_q;
   assign flow_out  = result_q;

endmodule

// File: hdl/versat_pkg.sv
package versat_pkg;

   localparam int DATA_W = 32;
   localparam int ADDR_W = 8;

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [2:0]        cfg_idx_t;

   // configuration register map inside a stage
   localparam cfg_idx_t CFG_OP    = 3'd0;
   localparam cfg_idx_t CFG_SRC   = 3'd1;
   localparam cfg_idx_t CFG_DST   = 3'd2;
   localparam cfg_idx_t CFG_ITER  = 3'd3;
   localparam cfg_idx_t CFG_CONST = 3'd4;
   localparam cfg_idx_t CFG_BSEL  = 3'd5;

   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_MAX  = 3'd5,
      ALU_PASS = 3'd6
   } alu_op_e;

   // one stage's run setup
   typedef struct packed {
      alu_op_e op;
      addr_t   src;
      addr_t   dst;
      addr_t   iter;
      data_t   const_val;
      logic    bsel;
   } stage_cfg_t;

   typedef struct packed {
      logic  valid;
      logic  we;
      addr_t addr;
      data_t wdata;
   } mem_req_t;

   typedef enum logic [1:0] {
      ENG_IDLE  = 2'd0,
      ENG_READ  = 2'd1,
      ENG_WAIT  = 2'd2,
      ENG_WRITE = 2'd3
   } engine_state_e;

endpackage

// File: hdl/versat_stage.sv
`timescale 1ns/100ps

module versat_stage #(
   parameter int MEM_AW = 5
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 run,
   input  logic                 cfg_valid,
   input  logic                 cfg_we,
   input  versat_pkg::cfg_idx_t cfg_idx,
   input  versat_pkg::data_t    cfg_wdata,
   input  logic                 host_valid,
   input  logic                 host_we,
   input  logic [MEM_AW-1:0]    host_addr,
   input  versat_pkg::data_t    host_wdata,
   input  versat_pkg::data_t    flow_in,
   output logic                 busy,
   output versat_pkg::data_t    cfg_rdata,
   output versat_pkg::data_t    host_rdata,
   output versat_pkg::data_t    flow_out
);
   import versat_pkg::*;

   stage_cfg_t cfg;
   mem_req_t   host_req;
   mem_req_t   rd_req;
   mem_req_t   wr_req;
   mem_req_t   mem_req;
   logic       rd_grant;
   logic       wr_grant;
   data_t      mem_rdata;
   data_t      operand_b;
   data_t      alu_result;
   alu_op_e    op;

   // host word address widened to the bus address
   assign host_req.valid = host_valid;
   assign host_req.we    = host_we;
   assign host_req.addr  = addr_t'(host_addr);
   assign host_req.wdata = host_wdata;

   assign host_rdata = mem_rdata;

   stage_config u_config (
      .clk       (clk),
      .rst_n     (rst_n),
      .cfg_valid (cfg_valid),
      .cfg_we    (cfg_we),
      .cfg_idx   (cfg_idx),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .cfg       (cfg)
   );

   stream_engine u_engine (
      .clk        (clk),
      .rst_n      (rst_n),
      .run        (run),
      .cfg        (cfg),
      .flow_in    (flow_in),
      .rd_grant   (rd_grant),
      .wr_grant   (wr_grant),
      .alu_result (alu_result),
      .busy       (busy),
      .rd_req     (rd_req),
      .wr_req     (wr_req),
      .operand_b  (operand_b),
      .op         (op),
      .flow_out   (flow_out)
   );

   mem_port_arbiter u_arbiter (
      .host_req (host_req),
      .rd_req   (rd_req),
      .wr_req   (wr_req),
      .mem_req  (mem_req),
      .rd_grant (rd_grant),
      .wr_grant (wr_grant)
   );

   stage_mem #(
      .MEM_AW(MEM_AW)
   ) u_mem (
      .clk     (clk),
      .mem_req (mem_req),
      .rdata   (mem_rdata)
   );

   stage_alu u_alu (
      .op     (op),
      .a      (mem_rdata),
      .b      (operand_b),
      .result (alu_result)
   );

endmodule

// File: hdl/versat_top.sv
`timescale 1ns/100ps

module versat_top #(
   parameter int NSTAGE = 2,
   parameter int MEM_AW = 5
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              ctr_valid,
   input  logic              ctr_we,
   input  versat_pkg::addr_t ctr_addr,
   input  versat_pkg::data_t ctr_data_in,
   output versat_pkg::data_t ctr_data_out,
   input  logic              data_valid,
   input  logic              data_we,
   input  versat_pkg::addr_t data_addr,
   input  versat_pkg::data_t data_data_in,
   output versat_pkg::data_t data_data_out
);
   import versat_pkg::*;

   localparam int SEL_W = (NSTAGE > 1) ? $clog2(NSTAGE) : 1;

   logic [NSTAGE-1:0] busy;
   logic [NSTAGE-1:0] cfg_sel;
   logic [NSTAGE-1:0] data_sel;
   data_t             cfg_rdata [NSTAGE];
   data_t             host_rdata [NSTAGE];
   data_t             flow [NSTAGE];
   logic              global_sel;
   logic              run;
   logic [SEL_W-1:0]  ctr_stage;
   logic [SEL_W-1:0]  data_stage;
   logic [SEL_W-1:0]  data_stage_q;

   // bit 7 picks the global register, otherwise a stage
   assign global_sel = ctr_addr[ADDR_W-1];
   assign ctr_stage  = ctr_addr[ADDR_W-2 -: SEL_W];
   assign data_stage = data_addr[ADDR_W-1 -: SEL_W];
   assign run        = ctr_valid & ctr_we & global_sel & ctr_data_in[0];

   always_comb begin
      cfg_sel  = '0;
      data_sel = '0;
      for (int j = 0; j < NSTAGE; j++) begin
         if (ctr_stage == SEL_W'(j))
            cfg_sel[j] = ctr_valid & ~global_sel;
         if (data_stage == SEL_W'(j))
            data_sel[j] = data_valid;
      end
   end

   // status or selected stage configuration
   always_comb begin
      ctr_data_out = '0;
      if (global_sel) begin
         ctr_data_out = data_t'(busy);
      end else begin
         for (int j = 0; j < NSTAGE; j++)
            if (ctr_stage == SEL_W'(j))
               ctr_data_out = cfg_rdata[j];
      end
   end

   // memory data shows up one cycle later, so remember who was asked
   always_ff @(posedge clk) begin
      if (!rst_n)
         data_stage_q <= '0;
      else if (data_valid && !data_we)
         data_stage_q <= data_stage;
   end

   always_comb begin
      data_data_out = '0;
      for (int j = 0; j < NSTAGE; j++)
         if (data_stage_q == SEL_W'(j))
            data_data_out = host_rdata[j];
   end

   for (genvar i = 0; i < NSTAGE; i++) begin : g_stage
      // stage 0 closes the ring on the last one
      localparam int PREV = (i == 0) ? NSTAGE - 1 : i - 1;

      versat_stage #(
         .MEM_AW(MEM_AW)
      ) u_stage (
         .clk        (clk),
         .rst_n      (rst_n),
         .run        (run),
         .cfg_valid  (cfg_sel[i]),
         .cfg_we     (ctr_we),
         .cfg_idx    (ctr_addr[2:0]),
         .cfg_wdata  (ctr_data_in),
         .host_valid (data_sel[i]),
         .host_we    (data_we),
         .host_addr  (data_addr[MEM_AW-1:0]),
         .host_wdata (data_data_in),
         .flow_in    (flow[PREV]),
         .busy       (busy[i]),
         .cfg_rdata  (cfg_rdata[i]),
         .host_rdata (host_rdata[i]),
         .flow_out   (flow[i])
      );
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module versat_tb -Mdir obj_dir -o versat_sim \
   -f versat_top.f > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }

./obj_dir/versat_sim > sim.log 2>&1
cat sim.log

grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// File: verification/versat_model.svh
`ifndef VERSAT_MODEL_SVH
`define VERSAT_MODEL_SVH

// mirrors of the stage memories, configuration sets and result registers
data_t       mem_mirror [NSTAGE][MEM_WORDS];
data_t       cfg_mirror [NSTAGE][8];
data_t       result_mirror [NSTAGE];
logic [31:0] lfsr_state = 32'h55b0e0cd;

// fibonacci lfsr with taps 32 22 2 1
function automatic data_t rand_bits(input int n);
   data_t r;
   logic  fb;
   r = '0;
   for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r = {r[30:0], fb};
   end
   return r;
endfunction

// bits kept by each configuration field
function automatic data_t field_mask(input cfg_idx_t idx);
   case (idx)
      CFG_OP:                     return 32'h7;
      CFG_SRC, CFG_DST, CFG_ITER: return 32'hff;
      CFG_CONST:                  return 32'hffff_ffff;
      CFG_BSEL:                   return 32'h1;
      default:                    return 32'h0;
   endcase
endfunction

function automatic data_t alu_ref(input logic [2:0] op, input data_t a, input data_t b);
   case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_MAX: return (a > b) ? a : b;
      default: return a;
   endcase
endfunction

// all stages latch b on the same edge, so take the old results first
task automatic model_run();
   data_t b [NSTAGE];
   int    src;
   int    dst;
   int    iter;
   for (int s = 0; s < NSTAGE; s++)
      b[s] = cfg_mirror[s][CFG_BSEL][0] ? result_mirror[(s + NSTAGE - 1) % NSTAGE]
                                        : cfg_mirror[s][CFG_CONST];
   for (int s = 0; s < NSTAGE; s++) begin
      src  = int'(cfg_mirror[s][CFG_SRC]);
      dst  = int'(cfg_mirror[s][CFG_DST]);
      iter = int'(cfg_mirror[s][CFG_ITER]);
      // reads see the words already written in this run
      for (int k = 0; k < iter; k++) begin
         mem_mirror[s][(dst + k) % MEM_WORDS] =
            alu_ref(cfg_mirror[s][CFG_OP][2:0], mem_mirror[s][(src + k) % MEM_WORDS], b[s]);
         result_mirror[s] = mem_mirror[s][(dst + k) % MEM_WORDS];
      end
   end
endtask

function automatic addr_t cfg_address(input int s, input cfg_idx_t idx);
   return addr_t'(s << (ADDR_W - 1 - SEL_W)) | addr_t'(idx);
endfunction

function automatic addr_t mem_address(input int s, input int w);
   return addr_t'(s << (ADDR_W - SEL_W)) | addr_t'(w);
endfunction

// host tasks start and end 1 ns after a rising edge
task automatic ctr_write(input addr_t a, input data_t v);
   ctr_valid   = 1'b1;
   ctr_we      = 1'b1;
   ctr_addr    = a;
   ctr_data_in = v;
   @(posedge clk);
   #1;
   ctr_valid = 1'b0;
   ctr_we    = 1'b0;
endtask

// control reads are combinational and sampled mid-cycle
task automatic ctr_read(input addr_t a, output data_t v);
   ctr_valid = 1'b1;
   ctr_we    = 1'b0;
   ctr_addr  = a;
   #4;
   v = ctr_data_out;
   @(posedge clk);
   #1;
   ctr_valid = 1'b0;
endtask

task automatic cfg_write(input int s, input cfg_idx_t idx, input data_t v);
   ctr_write(cfg_address(s, idx), v);
   cfg_mirror[s][idx] = v & field_mask(idx);
endtask

task automatic data_write(input int s, input int w, input data_t v);
   data_valid   = 1'b1;
   data_we      = 1'b1;
   data_addr    = mem_address(s, w);
   data_data_in = v;
   @(posedge clk);
   #1;
   data_valid = 1'b0;
   data_we    = 1'b0;
   mem_mirror[s][w] = v;
endtask

// read data is valid in the cycle after the request
task automatic data_read(input int s, input int w, output data_t v);
   data_valid = 1'b1;
   data_we    = 1'b0;
   data_addr  = mem_address(s, w);
   @(posedge clk);
   #1;
   data_valid = 1'b0;
   v = data_data_out;
endtask

`endif

// File: verification/versat_tb.sv
`timescale 1ns/100ps

module versat_tb;
   import versat_pkg::*;

   localparam int    NSTAGE      = 2;
   localparam int    MEM_AW      = 5;
   localparam int    MEM_WORDS   = 2 ** MEM_AW;
   localparam int    SEL_W       = (NSTAGE > 1) ? $clog2(NSTAGE) : 1;
   localparam addr_t STATUS_ADDR = 8'h80;
   localparam data_t ALL_BUSY    = data_t'((1 << NSTAGE) - 1);
   // about 2000 cycles of traffic over all six tests and the longest near 1200
   localparam int    TIMEOUT_CYCLES = 20000;

   logic  clk = 1'b0;
   logic  rst_n;
   logic  ctr_valid;
   logic  ctr_we;
   addr_t ctr_addr;
   data_t ctr_data_in;
   data_t ctr_data_out;
   logic  data_valid;
   logic  data_we;
   addr_t data_addr;
   data_t data_data_in;
   data_t data_data_out;

   int    cycles = 0;
   int    errors = 0;
   int    errors_before = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   string test_name;
   data_t reset_status;

   `include "versat_model.svh"

   versat_top #(
      .NSTAGE(NSTAGE),
      .MEM_AW(MEM_AW)
   ) DUT (
      .clk           (clk),
      .rst_n         (rst_n),
      .ctr_valid     (ctr_valid),
      .ctr_we        (ctr_we),
      .ctr_addr      (ctr_addr),
      .ctr_data_in   (ctr_data_in),
      .ctr_data_out  (ctr_data_out),
      .data_valid    (data_valid),
      .data_we       (data_we),
      .data_addr     (data_addr),
      .data_data_in  (data_data_in),
      .data_data_out (data_data_out)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $finish;
      end
   end

   task automatic start_test(input string name);
      test_name     = name;
      errors_before = errors;
   endtask

   task automatic finish_test();
      tests_run++;
      if (errors == errors_before) begin
         $display("test %s: ok", test_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", test_name, errors - errors_before);
      end
   endtask

   task automatic report_value(input string what, input data_t exp, input data_t act);
      errors++;
      $display("FAIL %s: %s expected %h actual %h", test_name, what, exp, act);
   endtask

   task automatic fill_memories();
      for (int s = 0; s < NSTAGE; s++)
         for (int w = 0; w < MEM_WORDS; w++)
            data_write(s, w, rand_bits(32));
   endtask

   task automatic check_memories();
      data_t got;
      for (int s = 0; s < NSTAGE; s++) begin
         for (int w = 0; w < MEM_WORDS; w++) begin
            data_read(s, w, got);
            if (got !== mem_mirror[s][w])
               report_value($sformatf("stage %0d word %0d", s, w), mem_mirror[s][w], got);
         end
      end
   endtask

   task automatic setup_stage(input int s, input int op, input int src, input int dst,
                              input int iter, input data_t cval, input logic bsel);
      cfg_write(s, CFG_OP, data_t'(op));
      cfg_write(s, CFG_SRC, data_t'(src));
      cfg_write(s, CFG_DST, data_t'(dst));
      cfg_write(s, CFG_ITER, data_t'(iter));
      cfg_write(s, CFG_CONST, cval);
      cfg_write(s, CFG_BSEL, data_t'(bsel));
   endtask

   task automatic start_run();
      ctr_write(STATUS_ADDR, 32'h1);
      model_run();
   endtask

   task automatic wait_idle();
      data_t st;
      st = '1;
      while (st[NSTAGE-1:0] != '0)
         ctr_read(STATUS_ADDR, st);
   endtask

   initial begin
      data_t got;
      int    s;
      int    w;
      rst_n        = 1'b0;
      ctr_valid    = 1'b0;
      ctr_we       = 1'b0;
      ctr_addr     = '0;
      ctr_data_in  = '0;
      data_valid   = 1'b0;
      data_we      = 1'b0;
      data_addr    = '0;
      data_data_in = '0;
      for (int i = 0; i < NSTAGE; i++) begin
         result_mirror[i] = '0;
         for (int j = 0; j < 8; j++)
            cfg_mirror[i][j] = '0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      ctr_read(STATUS_ADDR, reset_status);

      start_test("mem_load");
      fill_memories();
      for (int n = 0; n < 32; n++) begin
         s = int'(rand_bits(SEL_W) % NSTAGE);
         w = int'(rand_bits(MEM_AW));
         data_write(s, w, rand_bits(32));
      end
      check_memories();
      finish_test();

      start_test("cfg_readback");
      for (int i = 0; i < NSTAGE; i++)
         for (int j = 0; j < 8; j++)
            cfg_write(i, cfg_idx_t'(j), rand_bits(32));
      for (int i = 0; i < NSTAGE; i++) begin
         for (int j = 0; j < 8; j++) begin
            ctr_read(cfg_address(i, cfg_idx_t'(j)), got);
            if (got !== cfg_mirror[i][j])
               report_value($sformatf("stage %0d index %0d", i, j), cfg_mirror[i][j], got);
         end
      end
      finish_test();

      // every op against a constant with iter 0 to 8
      start_test("single_run");
      for (int op = 0; op < 7; op++) begin
         fill_memories();
         for (int i = 0; i < NSTAGE; i++)
            setup_stage(i, op, rand_bits(MEM_AW), rand_bits(MEM_AW), rand_bits(4) % 9,
                        rand_bits(32), 1'b0);
         start_run();
         wait_idle();
         check_memories();
      end
      finish_test();

      start_test("ring");
      for (int i = 0; i < NSTAGE; i++)
         setup_stage(i, rand_bits(3) % 7, rand_bits(MEM_AW), rand_bits(MEM_AW),
                     1 + rand_bits(3), rand_bits(32), 1'b0);
      start_run();
      wait_idle();
      // xor shows the predecessor's result directly
      for (int i = 0; i < NSTAGE; i++)
         setup_stage(i, ALU_XOR, rand_bits(MEM_AW), rand_bits(MEM_AW),
                     1 + rand_bits(3), rand_bits(32), 1'b1);
      start_run();
      wait_idle();
      check_memories();
      finish_test();

      // windows stay below word 23 and host traffic uses 24 to 31
      start_test("host_contention");
      for (int i = 0; i < NSTAGE; i++)
         setup_stage(i, rand_bits(3) % 7, rand_bits(3), 8 + rand_bits(3), 8,
                     rand_bits(32), 1'b0);
      start_run();
      for (int n = 0; n < 16; n++) begin
         s = int'(rand_bits(SEL_W) % NSTAGE);
         w = 24 + int'(rand_bits(3));
         if (n % 2 == 0) begin
            data_write(s, w, rand_bits(32));
         end else begin
            data_read(s, w, got);
            if (got !== mem_mirror[s][w])
               report_value($sformatf("busy read stage %0d word %0d", s, w),
                            mem_mirror[s][w], got);
         end
      end
      wait_idle();
      check_memories();
      finish_test();

      // in-place add so a repeated run would change the words
      start_test("run_protect");
      if (reset_status !== '0)
         report_value("busy after reset", '0, reset_status);
      for (int i = 0; i < NSTAGE; i++) begin
         w = int'(rand_bits(MEM_AW));
         setup_stage(i, ALU_ADD, w, w, 2 + rand_bits(3) % 7, rand_bits(32) | 32'h1, 1'b0);
      end
      start_run();
      ctr_read(STATUS_ADDR, got);
      if (got !== ALL_BUSY)
         report_value("busy right after a run", ALL_BUSY, got);
      ctr_write(STATUS_ADDR, 32'h1);
      wait_idle();
      check_memories();
      finish_test();

      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: versat_top.f
+incdir+verification
hdl/versat_pkg.sv
hdl/stage_alu.sv
hdl/stage_mem.sv
hdl/mem_port_arbiter.sv
hdl/stage_config.sv
hdl/stream_engine.sv
hdl/versat_stage.sv
hdl/versat_top.sv
verification/versat_tb.sv
